// ==== common/fdc_defines.svh ====
`ifndef FDC_DEFINES_SVH
`define FDC_DEFINES_SVH

// sector geometry, buffer depth follows the sector size
`define FDC_SECTOR_SIZE       1024
`define FDC_SECTORS_PER_TRACK 5
`define FDC_BUF_AW            ($clog2(`FDC_SECTOR_SIZE))

// timing in clock-enabled cycles
`define FDC_WATCHDOG_TIME     255 // max time a drq may wait for the host
`define FDC_DRQ_DELAY         16  // buffer fetch to drq

// disk agent status byte
`define FDC_ST_DONE    0
`define FDC_ST_OK      1
`define FDC_ST_CRC     2
`define FDC_ST_NOIMAGE 3 // no disk image loaded

// status register, type-I and type-II share some positions
`define FDC_SB_BUSY     0
`define FDC_SB_DRQ      1 // type-II
`define FDC_SB_LOST     2 // type-II
`define FDC_SB_TRACK0   2 // type-I
`define FDC_SB_CRC      3
`define FDC_SB_SEEK     4 // record not found on type-II
`define FDC_SB_HEADLOAD 5 // type-I
`define FDC_SB_NOTREADY 7

// secondary control register
`define FDC_CTL2_DRIVE 0
`define FDC_CTL2_SIDE  2

`endif

// ==== common/fdc_pkg.sv ====
`default_nettype none

package fdc_pkg;

	// --------------------------------------------------
	// host register bus
	// --------------------------------------------------
	typedef enum logic [2:0] {
		FDC_REG_CMD    = 3'b000, // command on write, status on read
		FDC_REG_TRACK  = 3'b001,
		FDC_REG_SECTOR = 3'b010,
		FDC_REG_DATA   = 3'b011,
		FDC_REG_CTL2   = 3'b111  // drive and side select
	} fdc_reg_e;

	typedef logic [7:0] fdc_byte_t;

	// --------------------------------------------------
	// disk agent requests
	// --------------------------------------------------
	// class in the upper nibble
	// low nibble is drive/side, or the command nibble for nop
	typedef enum logic [7:0] {
		FDC_REQ_READ     = 8'h10,
		FDC_REQ_WRITE    = 8'h20,
		FDC_REQ_READADDR = 8'h30,
		FDC_REQ_NOP      = 8'h40, // type-I, agent only answers done
		FDC_REQ_ACK      = 8'h80, // idle, nothing pending
		FDC_REQ_FAIL     = 8'hC0
	} fdc_req_e;

	// status register layout
	typedef enum logic {
		FDC_MODE_TYPE1 = 1'b0, // restore, seek, step
		FDC_MODE_TYPE2 = 1'b1  // reads, writes, read address
	} fdc_status_mode_e;

	// request class merged with its low nibble
	function automatic fdc_req_e fdc_req_code(fdc_req_e cls, logic [3:0] low);
		return fdc_req_e'({cls[7:4], low});
	endfunction

endpackage

`default_nettype wire

// ==== src/fdc_watchdog.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_defines.svh"

module fdc_watchdog (
	input  logic clk,
	input  logic cock,
	input  logic clken,
	input  logic kick,
	output logic expired
);

	localparam logic [15:0] RELOAD = 16'(`FDC_WATCHDOG_TIME);

	logic [15:0] timer;

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			timer <= '0; // out of reset already expired
		end else if (clken) begin
			if (kick)
				timer <= RELOAD;
			else if (timer != 16'd0)
				timer <= timer - 16'd1; // holds at zero
		end
	end

	assign expired = (timer == 16'd0);

endmodule

`default_nettype wire

// ==== src/fdc_sector_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_sector_buffer #(
	parameter int ADDR_W = 10
) (
	input  logic               clk,
	// disk agent side
	input  logic [ADDR_W-1:0]  wr_addr,
	input  logic               wr,
	input  fdc_pkg::fdc_byte_t wr_data,
	// controller side
	input  logic [ADDR_W-1:0]  rd_addr,
	input  logic               rd,
	output fdc_pkg::fdc_byte_t rd_data
);
	import fdc_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	fdc_byte_t mem [DEPTH]; // one sector

	// write port
	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_addr] <= wr_data;
	end

	// read port, data one cycle after rd
	always_ff @(posedge clk) begin
		if (rd)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== fdc/fdc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_defines.svh"

module fdc_core (
	input  logic                   clk,
	input  logic                   cock,
	input  logic                   clken,
	// host bus
	input  logic                   rd,
	input  logic                   wr,
	input  fdc_pkg::fdc_reg_e      addr,
	input  fdc_pkg::fdc_byte_t     wdata,
	output fdc_pkg::fdc_byte_t     rdata,
	output logic                   irq,
	output logic                   drq,
	// disk agent
	output fdc_pkg::fdc_req_e      req,
	input  logic [7:0]             req_status,
	// sector buffer read port
	output logic [`FDC_BUF_AW-1:0] buf_addr,
	output logic                   buf_rd,
	input  fdc_pkg::fdc_byte_t     buf_rdata,
	// watchdog
	input  logic                   expired,
	output logic                   kick
);
	import fdc_pkg::*;

	localparam int CNT_W = `FDC_BUF_AW + 1; // holds a full sector count
	localparam int DLY_W = $clog2(`FDC_DRQ_DELAY + 1);
	localparam logic [CNT_W-1:0] SECTOR_BYTES = CNT_W'(`FDC_SECTOR_SIZE);
	localparam logic [CNT_W-1:0] ID_BYTES     = CNT_W'(6); // read address field
	localparam logic [DLY_W-1:0] DRQ_WAIT     = DLY_W'(`FDC_DRQ_DELAY);
	localparam logic [7:0]       LAST_SECTOR  = 8'(`FDC_SECTORS_PER_TRACK);

	typedef enum logic [2:0] {
		ST_READY,      // idle, or waiting for the host to take a byte
		ST_WAIT_ACK,   // type-I nop pending
		ST_WAIT_READ,  // agent filling the buffer
		ST_WAIT_WRITE,
		ST_ADVANCE,    // next buffer address
		ST_FETCH,
		ST_DELAY,      // drq pacing
		ST_RESET       // force interrupt cleanup
	} state_e;

	state_e           state;
	fdc_byte_t        track_reg;
	fdc_byte_t        sector_reg;
	fdc_byte_t        data_reg;
	logic [7:0]       head_pos;   // real head position
	logic             drive;
	logic             side;
	logic             step_out;   // last step direction
	logic             multi;
	logic             busy;
	logic             head_loaded;
	logic             seek_err;
	logic             crc_err;
	logic             lost;
	logic             not_ready;
	logic             force_irq;
	fdc_status_mode_e status_mode;
	logic [CNT_W-1:0] remaining;  // bytes left incl. the one on offer
	logic [DLY_W-1:0] delay;
	fdc_byte_t        status;
	fdc_byte_t        ctl2_rd;

	logic       step_dir;
	logic [7:0] next_track;
	logic       data_rd;
	logic       read_ok;
	logic       read_fail;
	logic       lost_evt;
	logic       last_byte;

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	assign step_dir   = wdata[6] ? wdata[5] : step_out; // plain step keeps direction
	assign next_track = step_dir ? head_pos - 8'd1 : head_pos + 8'd1;

	assign data_rd   = (state == ST_READY) && drq && rd && (addr == FDC_REG_DATA);
	assign lost_evt  = (state == ST_READY) && drq && expired && !data_rd;
	assign last_byte = (remaining == CNT_W'(1));

	assign read_ok = (state == ST_WAIT_READ) && !req_status[`FDC_ST_NOIMAGE] &&
		req_status[`FDC_ST_DONE] && req_status[`FDC_ST_OK];
	assign read_fail = (state == ST_WAIT_READ) && (req_status[`FDC_ST_NOIMAGE] ||
		(req_status[`FDC_ST_DONE] && !req_status[`FDC_ST_OK]));

	assign kick   = read_ok || data_rd || lost_evt; // each byte gets a full window
	assign buf_rd = clken && (state == ST_FETCH);

	// status byte, layout follows the last command class
	always_comb begin
		status = '0;
		status[`FDC_SB_BUSY]     = busy;
		status[`FDC_SB_CRC]      = crc_err;
		status[`FDC_SB_SEEK]     = seek_err;
		status[`FDC_SB_NOTREADY] = not_ready;
		if (status_mode == FDC_MODE_TYPE1) begin
			status[`FDC_SB_TRACK0]   = (head_pos == 8'd0);
			status[`FDC_SB_HEADLOAD] = head_loaded;
		end else begin
			status[`FDC_SB_DRQ]  = drq;
			status[`FDC_SB_LOST] = lost;
		end
	end

	always_comb begin
		ctl2_rd = '1; // unused bits read as one
		ctl2_rd[`FDC_CTL2_DRIVE] = drive;
		ctl2_rd[`FDC_CTL2_SIDE]  = side;
	end

	// data register, host writes it for seek, fetch fills it
	always_ff @(posedge clk) begin
		if (clken) begin
			if (wr && addr == FDC_REG_DATA)
				data_reg <= wdata;
			else if (state == ST_DELAY && delay == '0)
				data_reg <= buf_rdata; // byte offered with drq
		end
	end

	// --------------------------------------------------
	// registers and transfer FSM
	// --------------------------------------------------
	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state       <= ST_READY;
			req         <= FDC_REQ_ACK;
			rdata       <= '0;
			irq         <= 1'b0;
			drq         <= 1'b0;
			busy        <= 1'b0;
			multi       <= 1'b0;
			force_irq   <= 1'b0;
			step_out    <= 1'b0;
			drive       <= 1'b0;
			side        <= 1'b0;
			head_loaded <= 1'b0;
			seek_err    <= 1'b0;
			crc_err     <= 1'b0;
			lost        <= 1'b0;
			not_ready   <= 1'b0;
			status_mode <= FDC_MODE_TYPE1;
			head_pos    <= 8'hff; // unknown until restore
			track_reg   <= '0;
			sector_reg  <= '0;
			remaining   <= '0;
			delay       <= '0;
			buf_addr    <= '0;
		end else if (clken) begin
			not_ready <= req_status[`FDC_ST_NOIMAGE];

			// host reads, status read acknowledges irq
			if (rd) begin
				case (addr)
					FDC_REG_CMD: begin
						rdata <= status;
						irq   <= 1'b0;
					end
					FDC_REG_TRACK:  rdata <= track_reg;
					FDC_REG_SECTOR: rdata <= sector_reg;
					FDC_REG_DATA:   rdata <= data_reg;
					FDC_REG_CTL2:   rdata <= ctl2_rd;
					default:        rdata <= '1;
				endcase
			end

			case (state)
				ST_READY: begin
					if (data_rd || lost_evt) begin
						drq  <= 1'b0;
						lost <= lost_evt; // a taken byte clears it
						if (!last_byte) begin
							state <= ST_ADVANCE;
						end else if (multi && sector_reg < LAST_SECTOR) begin
							// next sector on the same track
							sector_reg <= sector_reg + 8'd1;
							remaining  <= SECTOR_BYTES;
							req        <= fdc_req_code(FDC_REQ_READ, {2'b00, drive, side});
							state      <= ST_WAIT_READ;
						end else begin
							busy  <= 1'b0;
							multi <= 1'b0;
							irq   <= 1'b1;
						end
					end
				end
				ST_WAIT_ACK: begin
					if (req_status[`FDC_ST_DONE]) begin
						req   <= FDC_REQ_ACK;
						busy  <= 1'b0;
						irq   <= 1'b1;
						state <= ST_READY;
					end
				end
				ST_WAIT_READ: begin
					if (read_fail) begin
						req      <= FDC_REQ_ACK;
						seek_err <= 1'b1;
						crc_err  <= req_status[`FDC_ST_CRC];
						busy     <= 1'b0;
						multi    <= 1'b0;
						irq      <= 1'b1;
						state    <= ST_READY;
					end else if (read_ok) begin
						req      <= FDC_REQ_ACK;
						buf_addr <= '0;
						state    <= ST_FETCH;
					end
				end
				ST_WAIT_WRITE: begin
					// no write path, fail right away
					req      <= FDC_REQ_ACK;
					seek_err <= 1'b1;
					busy     <= 1'b0;
					irq      <= 1'b1;
					state    <= ST_READY;
				end
				ST_ADVANCE: begin
					buf_addr  <= buf_addr + 1'b1;
					remaining <= remaining - 1'b1;
					state     <= ST_FETCH;
				end
				ST_FETCH: begin
					delay <= DRQ_WAIT; // buffer read issued this cycle
					state <= ST_DELAY;
				end
				ST_DELAY: begin
					if (delay != '0) begin
						delay <= delay - 1'b1;
					end else begin
						drq   <= 1'b1;
						state <= ST_READY;
					end
				end
				ST_RESET: begin
					req      <= FDC_REQ_ACK;
					drq      <= 1'b0;
					busy     <= 1'b0;
					multi    <= 1'b0;
					seek_err <= 1'b0;
					crc_err  <= 1'b0;
					lost     <= 1'b0;
					irq      <= force_irq; // immediate interrupt flag
					state    <= ST_READY;
				end
				default: state <= ST_READY;
			endcase

			// host writes, after the FSM so a command overrides it
			if (wr) begin
				case (addr)
					FDC_REG_TRACK:  if (!busy) track_reg <= wdata;
					FDC_REG_SECTOR: if (!busy) sector_reg <= wdata;
					FDC_REG_CTL2: begin
						drive <= wdata[`FDC_CTL2_DRIVE];
						side  <= wdata[`FDC_CTL2_SIDE];
					end
					FDC_REG_CMD: begin
						if (wdata[7:4] == 4'hD) begin
							// force interrupt, any state
							force_irq <= wdata[3];
							irq       <= 1'b0;
							state     <= ST_RESET;
						end else if (state == ST_READY && !busy) begin
							irq         <= 1'b0;
							status_mode <= fdc_status_mode_e'(wdata[7]);
							seek_err    <= 1'b0;
							crc_err     <= 1'b0;
							lost        <= 1'b0;
							if (!wdata[7]) begin
								// type-I common part
								head_loaded <= wdata[3];
								busy        <= 1'b1;
								req         <= fdc_req_code(FDC_REQ_NOP, wdata[7:4]);
								state       <= ST_WAIT_ACK;
							end
							case (wdata[7:4])
								4'h0: begin // restore
									track_reg <= '0;
									head_pos  <= 8'd0;
								end
								4'h1: head_pos <= data_reg; // seek
								4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
									if (wdata[6])
										step_out <= wdata[5];
									head_pos <= next_track;
									if (wdata[4])
										track_reg <= next_track; // update flag
								end
								4'h8, 4'h9: begin // read sector
									busy      <= 1'b1;
									multi     <= wdata[4];
									remaining <= SECTOR_BYTES;
									req       <= fdc_req_code(FDC_REQ_READ, {2'b00, drive, side});
									state     <= ST_WAIT_READ;
								end
								4'hA, 4'hB: begin // write sector
									busy  <= 1'b1;
									req   <= fdc_req_code(FDC_REQ_WRITE, {2'b00, drive, side});
									state <= ST_WAIT_WRITE;
								end
								4'hC: begin // read address
									busy      <= 1'b1;
									multi     <= 1'b0;
									remaining <= ID_BYTES;
									req <= fdc_req_code(FDC_REQ_READADDR, {2'b00, drive, side});
									state     <= ST_WAIT_READ;
								end
								default: ; // read/write track ignored
							endcase
						end
					end
					default: ; // data register has its own block
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/fdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_defines.svh"

module fdc_top (
	input  logic                   clk,
	input  logic                   cock,
	input  logic                   clken,
	// host bus
	input  logic                   rd,
	input  logic                   wr,
	input  fdc_pkg::fdc_reg_e      addr,
	input  fdc_pkg::fdc_byte_t     wdata,
	output fdc_pkg::fdc_byte_t     rdata,
	output logic                   irq,
	output logic                   drq,
	// disk agent
	output fdc_pkg::fdc_req_e      req,
	input  logic [7:0]             req_status,
	input  logic [`FDC_BUF_AW-1:0] img_addr,
	input  logic                   img_wr,
	input  fdc_pkg::fdc_byte_t     img_wdata
);

	logic [`FDC_BUF_AW-1:0] buf_addr;
	logic                   buf_rd;
	fdc_pkg::fdc_byte_t     buf_rdata;
	logic                   kick;
	logic                   expired;

	fdc_core u_core (
		.clk        (clk),
		.cock       (cock),
		.clken      (clken),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.wdata      (wdata),
		.rdata      (rdata),
		.irq        (irq),
		.drq        (drq),
		.req        (req),
		.req_status (req_status),
		.buf_addr   (buf_addr),
		.buf_rd     (buf_rd),
		.buf_rdata  (buf_rdata),
		.expired    (expired),
		.kick       (kick)
	);

	// lost-data timer
	fdc_watchdog u_watchdog (
		.clk     (clk),
		.cock    (cock),
		.clken   (clken),
		.kick    (kick),
		.expired (expired)
	);

	// agent writes, core reads
	fdc_sector_buffer #(
		.ADDR_W (`FDC_BUF_AW)
	) u_buffer (
		.clk     (clk),
		.wr_addr (img_addr),
		.wr      (img_wr),
		.wr_data (img_wdata),
		.rd_addr (buf_addr),
		.rd      (buf_rd),
		.rd_data (buf_rdata)
	);

endmodule

`default_nettype wire

// ==== tests/fdc_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_properties (
	input logic                        clk,
	input logic                        cock,
	input logic                        drq,
	input logic                        irq,
	input logic                        busy,
	input fdc_pkg::fdc_status_mode_e   status_mode,
	input fdc_pkg::fdc_req_e           req
);
	import fdc_pkg::*;

	// --------------------------------------------------
	// control output rules
	// --------------------------------------------------
	drq_needs_busy: assert property (@(posedge clk) disable iff (cock)
		$rose(drq) |-> busy && status_mode == FDC_MODE_TYPE2)
		else $error("drq rose outside a busy type-II command");

	// first cycle out of reset
	req_idle_after_reset: assert property (@(posedge clk)
		$fell(cock) |-> req == FDC_REQ_ACK)
		else $error("req not idle after reset release");

	irq_busy_exclusive: assert property (@(posedge clk) disable iff (cock)
		!(irq && busy))
		else $error("irq and busy high together");

endmodule

bind fdc_top fdc_properties u_properties (
	.clk         (clk),
	.cock        (cock),
	.drq         (drq),
	.irq         (irq),
	.busy        (u_core.busy),        // internal busy flag
	.status_mode (u_core.status_mode),
	.req         (req)
);

`default_nettype wire

// ==== tests/fdc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fdc_defines.svh"

module fdc_tb;
	import fdc_pkg::*;

	localparam int TMO = 3000; // cycles per wait

	logic                   clk = 1'b0;
	logic                   cock;
	logic                   clken;
	logic                   rd;
	logic                   wr;
	fdc_reg_e               addr;
	fdc_byte_t              wdata;
	fdc_byte_t              rdata;
	logic                   irq;
	logic                   drq;
	fdc_req_e               req;
	logic [7:0]             req_status;
	logic [`FDC_BUF_AW-1:0] img_addr;
	logic                   img_wr;
	fdc_byte_t              img_wdata;

	int        errors = 0;
	int        checks = 0;
	fdc_req_e  req_log[$];      // requests seen by the agent
	fdc_byte_t model_head;      // expected head position
	fdc_byte_t agent_sector;
	bit        agent_fail = 0;  // answer done only
	bit        agent_crc = 0;
	bit        agent_off = 0;   // agent ignores requests

	fdc_top i_dut (.*);

	always #5 clk = ~clk;

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic fdc_byte_t ref_byte(fdc_byte_t trk, bit sd, fdc_byte_t sec, int off);
		logic [15:0] o;
		o = 16'(off);
		return o[7:0] ^ (o[15:8] * 8'h3B) ^ (trk * 8'h11) ^ (sec * 8'h27) ^ (sd ? 8'hA5 : 8'h00);
	endfunction

	function automatic fdc_byte_t predict_status(fdc_status_mode_e mode, bit busy, bit drq_f,
		bit lost_f, bit trk0, bit hl, bit crc, bit seek, bit nr);
		fdc_byte_t s;
		s = '0;
		s[`FDC_SB_BUSY]     = busy;
		s[`FDC_SB_CRC]      = crc;
		s[`FDC_SB_SEEK]     = seek;
		s[`FDC_SB_NOTREADY] = nr;
		if (mode == FDC_MODE_TYPE1) begin
			s[`FDC_SB_TRACK0]   = trk0;
			s[`FDC_SB_HEADLOAD] = hl;
		end else begin
			s[`FDC_SB_DRQ]  = drq_f;
			s[`FDC_SB_LOST] = lost_f;
		end
		return s;
	endfunction

	// --------------------------------------------------
	// compare and end of run
	// --------------------------------------------------
	task automatic end_run();
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic stop_on_timeout(string what);
		$display("%0t: timed out waiting for %s", $time, what);
		errors++;
		end_run();
	endtask

	task automatic check_byte(string name, fdc_byte_t got, fdc_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic check_status(string name, fdc_byte_t got, fdc_byte_t exp, fdc_byte_t mask);
		checks++;
		if ((got & mask) !== (exp & mask)) begin
			errors++;
			$display("[FAIL] %0t %s: got %02h expected %02h (mask %02h)",
				$time, name, got, exp, mask);
		end
	endtask

	task automatic check_req(string name, fdc_req_e got, fdc_req_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	// request log against n copies of one code
	task automatic check_reqs(fdc_req_e exp, int n);
		checks++;
		if (req_log.size() != n) begin
			errors++;
			$display("%0t: agent saw %0d requests instead of %0d", $time, req_log.size(), n);
		end
		foreach (req_log[i])
			check_req("req", req_log[i], exp);
		req_log.delete();
	endtask

	// --------------------------------------------------
	// host bus, all calls start 1 ns after an edge
	// --------------------------------------------------
	task automatic bus_write(fdc_reg_e a, fdc_byte_t d);
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		@(posedge clk);
		#1 wr = 1'b0;
	endtask

	task automatic bus_read(fdc_reg_e a, output fdc_byte_t d);
		addr = a;
		rd   = 1'b1;
		@(posedge clk);
		#1 rd = 1'b0;
		d = rdata; // registered on that edge
	endtask

	task automatic wait_drq();
		int n;
		n = 0;
		while (!drq && n < TMO) begin
			@(posedge clk);
			#1 n++;
		end
		if (!drq)
			stop_on_timeout("drq");
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (!irq && n < TMO) begin
			@(posedge clk);
			#1 n++;
		end
		if (!irq)
			stop_on_timeout("irq");
	endtask

	task automatic read_bytes(fdc_byte_t trk, bit sd, fdc_byte_t sec, int nbytes);
		fdc_byte_t v;
		for (int i = 0; i < nbytes; i++) begin
			wait_drq();
			bus_read(FDC_REG_DATA, v);
			check_byte("data", v, ref_byte(trk, sd, sec, i));
		end
	endtask

	task automatic status_is(fdc_byte_t exp, fdc_byte_t mask);
		fdc_byte_t v;
		bus_read(FDC_REG_CMD, v);
		check_status("status", v, exp, mask);
	endtask

	task automatic type1_cmd(fdc_byte_t cmd);
		bus_write(FDC_REG_CMD, cmd);
		wait_irq();
		check_reqs(fdc_req_e'({4'h4, cmd[7:4]}), 1);
	endtask

	// --------------------------------------------------
	// disk agent model
	// --------------------------------------------------
	initial begin
		int n;
		img_addr  = '0;
		img_wr    = 1'b0;
		img_wdata = '0;
		forever begin
			@(posedge clk);
			#2;
			if (!cock && !agent_off && req != FDC_REQ_ACK) begin
				req_log.push_back(req);
				if (req[7:4] == 4'h2)
					continue; // no write path, core fails on its own
				if (agent_fail) begin
					req_status = agent_crc ? 8'h05 : 8'h01;
				end else begin
					if (req[7:4] == 4'h1 || req[7:4] == 4'h3) begin
						for (int i = 0; i < (req[7:4] == 4'h1 ? `FDC_SECTOR_SIZE : 6); i++) begin
							img_addr  = i;
							img_wdata = ref_byte(model_head, req[0],
								req[7:4] == 4'h1 ? agent_sector : 8'hFF, i);
							img_wr    = 1'b1;
							@(posedge clk);
							#2;
						end
						img_wr = 1'b0;
						if (req[7:4] == 4'h1)
							agent_sector++;
					end
					req_status = 8'h03; // done and ok
				end
				n = 0;
				while (req != FDC_REQ_ACK && n < 100) begin
					@(posedge clk);
					#2 n++;
				end
				if (req != FDC_REQ_ACK)
					stop_on_timeout("req to return to ack");
				req_status = 8'h00;
			end
		end
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		fdc_byte_t t;
		fdc_byte_t s;
		fdc_byte_t c;
		fdc_byte_t v;
		void'($urandom(32'h14651890));
		cock       = 1'b1;
		clken      = 1'b1;
		rd         = 1'b0;
		wr         = 1'b0;
		addr       = FDC_REG_CMD;
		wdata      = '0;
		req_status = '0;
		model_head = '0;
		repeat (10) @(posedge clk);
		#1 cock = 1'b0;
		@(posedge clk);
		#1;

		// register read back
		t = $urandom;
		s = $urandom;
		c = $urandom;
		bus_write(FDC_REG_TRACK, t);
		bus_write(FDC_REG_SECTOR, s);
		bus_write(FDC_REG_CTL2, c);
		bus_read(FDC_REG_TRACK, v);
		check_byte("track", v, t);
		bus_read(FDC_REG_SECTOR, v);
		check_byte("sector", v, s);
		bus_read(FDC_REG_CTL2, v);
		check_byte("ctl2", v, (c & 8'h05) | 8'hFA);

		// type-I
		type1_cmd(8'h08); // restore, head load
		status_is(predict_status(FDC_MODE_TYPE1, 0, 0, 0, 1, 1, 0, 0, 0), 8'hBD);
		bus_read(FDC_REG_TRACK, v);
		check_byte("track", v, 8'h00);
		type1_cmd(8'h50); // step-in, update
		type1_cmd(8'h50);
		bus_read(FDC_REG_TRACK, v);
		check_byte("track", v, 8'h02);
		type1_cmd(8'h60); // step-out, no update, head at 1
		bus_read(FDC_REG_TRACK, v);
		check_byte("track", v, 8'h02);
		type1_cmd(8'h30); // plain step keeps out, head at 0
		bus_read(FDC_REG_TRACK, v);
		check_byte("track", v, 8'h00);
		status_is(predict_status(FDC_MODE_TYPE1, 0, 0, 0, 1, 0, 0, 0, 0), 8'hBD);
		bus_write(FDC_REG_DATA, 8'h27);
		type1_cmd(8'h10); // seek to 0x27
		status_is(predict_status(FDC_MODE_TYPE1, 0, 0, 0, 0, 0, 0, 0, 0), 8'hBD);
		type1_cmd(8'h50); // head now 0x28
		bus_read(FDC_REG_TRACK, v);
		check_byte("track", v, 8'h28);
		model_head = 8'h28;

		// single sector, register writes ignored while busy
		bus_write(FDC_REG_CTL2, 8'h00);
		bus_write(FDC_REG_SECTOR, 8'h01);
		agent_sector = 8'h01;
		bus_write(FDC_REG_CMD, 8'h80);
		bus_write(FDC_REG_TRACK, 8'h99);
		bus_write(FDC_REG_SECTOR, 8'h04);
		bus_read(FDC_REG_TRACK, v);
		check_byte("track", v, 8'h28);
		bus_read(FDC_REG_SECTOR, v);
		check_byte("sector", v, 8'h01);
		read_bytes(8'h28, 0, 8'h01, `FDC_SECTOR_SIZE);
		wait_irq();
		status_is(predict_status(FDC_MODE_TYPE2, 0, 0, 0, 0, 0, 0, 0, 0), 8'h9F);
		check_reqs(FDC_REQ_READ, 1);

		// multi-sector on side 1, then read address
		bus_write(FDC_REG_CTL2, 8'h04);
		bus_write(FDC_REG_SECTOR, 8'h03);
		agent_sector = 8'h03;
		bus_write(FDC_REG_CMD, 8'h90);
		for (int sec = 3; sec <= `FDC_SECTORS_PER_TRACK; sec++)
			read_bytes(8'h28, 1, fdc_byte_t'(sec), `FDC_SECTOR_SIZE);
		wait_irq();
		check_reqs(fdc_req_e'(8'h11), 3);
		bus_read(FDC_REG_SECTOR, v);
		check_byte("sector", v, 8'h05);
		bus_write(FDC_REG_CMD, 8'hC0);
		read_bytes(8'h28, 1, 8'hFF, 6);
		wait_irq();
		check_reqs(fdc_req_e'(8'h31), 1);
		bus_write(FDC_REG_CTL2, 8'h00);

		// crc failure answered with done only
		agent_fail = 1;
		agent_crc  = 1;
		bus_write(FDC_REG_CMD, 8'h80);
		wait_irq();
		check_byte("drq", {7'd0, drq}, 8'h00);
		status_is(predict_status(FDC_MODE_TYPE2, 0, 0, 0, 0, 0, 1, 1, 0), 8'h9F);
		check_reqs(FDC_REQ_READ, 1);
		agent_fail = 0;
		agent_crc  = 0;

		// no image
		agent_off  = 1;
		req_status = 8'h08;
		bus_write(FDC_REG_CMD, 8'h80);
		wait_irq();
		status_is(predict_status(FDC_MODE_TYPE2, 0, 0, 0, 0, 0, 0, 1, 1), 8'h9F);
		req_status = 8'h00;
		agent_off  = 0;
		req_log.delete();

		// write sector has no path
		bus_write(FDC_REG_CMD, 8'hA0);
		wait_irq();
		status_is(predict_status(FDC_MODE_TYPE2, 0, 0, 0, 0, 0, 0, 1, 0), 8'h9F);
		check_reqs(FDC_REQ_WRITE, 1);

		// lost data on byte 1
		bus_write(FDC_REG_SECTOR, 8'h02);
		agent_sector = 8'h02;
		bus_write(FDC_REG_CMD, 8'h80);
		read_bytes(8'h28, 0, 8'h02, 1);
		wait_drq();
		for (int n = 0; n < 400 && drq; n++) begin
			@(posedge clk);
			#1;
		end
		if (drq)
			stop_on_timeout("drq to drop after the watchdog");
		status_is(8'h05, 8'h05); // busy and lost
		wait_drq();
		bus_read(FDC_REG_DATA, v);
		check_byte("data", v, ref_byte(8'h28, 0, 8'h02, 2));
		status_is(8'h00, 8'h04);

		// force interrupt mid sector
		wait_drq();
		bus_write(FDC_REG_CMD, 8'hD0);
		repeat (2) @(posedge clk);
		#1;
		status_is(8'h00, 8'h03);
		for (int n = 0; n < 50; n++) begin
			if (drq || irq) begin
				errors++;
				$display("%0t: drq or irq active after force interrupt", $time);
				break;
			end
			@(posedge clk);
			#1;
		end
		check_reqs(FDC_REQ_READ, 1);

		// force interrupt while the read request is still pending
		agent_off = 1;
		bus_write(FDC_REG_CMD, 8'h80);
		check_req("req", req, FDC_REQ_READ);
		bus_write(FDC_REG_CMD, 8'hD0);
		@(posedge clk);
		#1 check_req("req", req, FDC_REQ_ACK);
		status_is(8'h00, 8'h01);
		agent_off = 0;

		end_run();
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/fdc_pkg.sv
src/fdc_watchdog.sv
src/fdc_sector_buffer.sv
fdc/fdc_core.sv
src/fdc_top.sv
tests/fdc_properties.sv
tests/fdc_tb.sv

// ==== Bender.yml ====
package:
  name: fdc

sources:
  - target: rtl
    include_dirs:
      - common
    files:
      - common/fdc_pkg.sv
      - src/fdc_watchdog.sv
      - src/fdc_sector_buffer.sv
      - fdc/fdc_core.sv
      - src/fdc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/fdc_properties.sv
      - tests/fdc_tb.sv
